// ==== acc_config.svh ====
`ifndef ACC_CONFIG_SVH
`define ACC_CONFIG_SVH

//////////////////////////////
// FIFO sizing
//////////////////////////////

`define ACC_FIFO_DEPTH 16         // Entries per FIFO as a power of two
`define ACC_ALMOST_FULL_MARGIN 8  // Room kept back for one whole packet

//////////////////////////////
// Datapath
//////////////////////////////

`define ACC_ADD_STAGES 2          // operand_adder latency

// Largest outgoing size code where 3 means 8 items
`define ACC_MAX_SIZE_CODE 3

`endif

// ==== acc_pkg.sv ====
`default_nettype none

package acc_pkg;

   typedef logic [31:0] word_t;   // One stream word
   typedef logic [63:0] result_t; // One operand or one sum

   // Tile coordinates with x in the upper bits
   typedef struct packed {
      logic [2:0] x;
      logic [2:0] y;
   } tile_id_t;

   typedef enum logic [2:0] {
      QPUT = 3'd3,
      MPUT = 3'd4
   } opcode_t;

   // Route code from header word 1
   // Code 3 is treated as a return as well
   typedef enum logic [1:0] {
      ROUTE_RETURN  = 2'd0,
      ROUTE_FORWARD = 2'd1,
      ROUTE_FINAL   = 2'd2
   } route_t;

endpackage

`default_nettype wire

// ==== stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One word stream with valid/ready/last handshake
interface stream_if;

   logic        valid;
   logic [31:0] data;
   logic        last;  // Final word of a packet
   logic        ready;

   modport sender (
      output valid, data, last,
      input  ready
   );

   modport receiver (
      input  valid, data, last,
      output ready
   );

endinterface

`default_nettype wire

// ==== sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "acc_config.svh"

// First-word-fall-through FIFO with the head entry always on rd_data
module sync_fifo
   import acc_pkg::*;
#(
   parameter type payload_t = word_t
) (
   input  wire logic     clk_ctrl,
   input  wire logic     clk_ctrl_rst_low,
   input  wire logic     wr_en,
   input  wire payload_t wr_data,
   input  wire logic     rd_en,
   output payload_t      rd_data,
   output logic          empty,
   output logic          almost_full
);

   localparam int DEPTH = `ACC_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_wr;
   logic             do_rd;

   assign do_wr = wr_en && (count != CNT_W'(DEPTH)); // Drop writes when full
   assign do_rd = rd_en && !empty;

   always_ff @(posedge clk_ctrl) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + 1'b1; // Wraps since depth is a power of two
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign rd_data = mem[rd_ptr];
   assign empty   = (count == '0);

   // No more than the margin left free
   assign almost_full = (count >= CNT_W'(DEPTH - `ACC_ALMOST_FULL_MARGIN));

endmodule

`default_nettype wire

// ==== packet_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "acc_config.svh"

module packet_decoder
   import acc_pkg::*;
(
   input  wire logic     clk_ctrl,
   input  wire logic     clk_ctrl_rst_low,
   input  wire tile_id_t src_id,
   stream_if.receiver    stream_in,
   input  wire logic     hdr_full,
   input  wire logic     res_full,
   output logic          hdr_wr_en,
   output word_t         hdr_data,
   output logic          item_valid,
   output result_t       item_a,
   output result_t       item_b
);

   typedef enum logic [2:0] {
      ST_HDR0, ST_HDR1, ST_FIRST_HI, ST_A_LO, ST_B, ST_A_HI
   } state_t;

   state_t     state;
   state_t     state_d;
   word_t      hdr0_q;      // Header word 0 as received
   logic [1:0] code_q;
   tile_id_t   dest_q;
   result_t    a_q;         // Operand a being assembled
   logic [3:0] size_code;
   route_t     route;
   opcode_t    opcode;
   logic [5:0] target;
   logic [1:0] code_d;
   tile_id_t   dest_d;
   logic       take;

   assign take = stream_in.valid && stream_in.ready;

   // Outgoing size code clamped to the largest legal one
   always_comb begin
      size_code = hdr0_q[11:8] - 4'd1;
      if (size_code > 4'(`ACC_MAX_SIZE_CODE)) size_code = 4'(`ACC_MAX_SIZE_CODE);
   end

   //////////////////////////////
   // Route rules
   //////////////////////////////

   always_comb begin
      if (stream_in.data[9:8] == 2'd1)      route = ROUTE_FORWARD;
      else if (stream_in.data[9:8] == 2'd2) route = ROUTE_FINAL;
      else                                  route = ROUTE_RETURN;
      opcode = QPUT;
      target = stream_in.data[5:0];
      code_d = 2'd0;
      dest_d = '0;
      case (route)
         ROUTE_FORWARD: begin
            opcode = MPUT;
            code_d = 2'd2;
            dest_d = hdr0_q[23:18];
         end
         ROUTE_FINAL:  ;                      // Defaults already hold
         ROUTE_RETURN: target = hdr0_q[23:18]; // Back to the sender
         default:      ;
      endcase
   end

   always_comb begin
      state_d         = state;
      stream_in.ready = 1'b1;
      hdr_wr_en       = 1'b0;
      hdr_data        = '0;
      item_valid      = 1'b0;
      case (state)
         ST_HDR0: begin
            stream_in.ready = !hdr_full && !res_full; // Admit only with room
            if (take) state_d = ST_HDR1;
         end
         ST_HDR1: if (take) begin
            hdr_wr_en = 1'b1;
            hdr_data  = {3'b000, 1'b1, opcode, 1'b0, src_id, 6'h00, size_code, 2'b00, target};
            state_d   = ST_FIRST_HI;
         end
         ST_FIRST_HI: if (take) begin
            hdr_wr_en = 1'b1;  // Second header word goes out with the first a word
            hdr_data  = {22'h0, code_q, 2'b00, dest_q};
            state_d   = ST_A_LO;
         end
         ST_A_HI: if (take) state_d = ST_A_LO;
         ST_A_LO: if (take) state_d = ST_B;
         ST_B: if (take) begin
            item_valid = 1'b1;
            state_d    = stream_in.last ? ST_HDR0 : ST_A_HI;
         end
         default: state_d = ST_HDR0;
      endcase
   end

   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) state <= ST_HDR0;
      else                   state <= state_d;
   end

   always_ff @(posedge clk_ctrl) begin
      if (take) begin
         if (state == ST_HDR0) hdr0_q <= stream_in.data;
         if (state == ST_HDR1) begin
            code_q <= code_d;
            dest_q <= dest_d;
         end
         if (state == ST_FIRST_HI || state == ST_A_HI) a_q[63:32] <= stream_in.data;
         if (state == ST_A_LO) a_q[31:0] <= stream_in.data;
      end
   end

   assign item_a = a_q;
   assign item_b = {32'h0, stream_in.data}; // b is zero-extended

endmodule

`default_nettype wire

// ==== operand_adder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "acc_config.svh"

module operand_adder
   import acc_pkg::*;
(
   input  wire logic    clk_ctrl,
   input  wire logic    clk_ctrl_rst_low,
   input  wire logic    item_valid,
   input  wire result_t item_a,
   input  wire result_t item_b,
   output logic         sum_valid,
   output result_t      sum
);

   logic [`ACC_ADD_STAGES-1:0] valid_pipe;
   logic [32:0]                lo_q;     // Low half with carry out
   logic [31:0]                a_hi_q;
   logic [31:0]                b_hi_q;

   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) valid_pipe <= '0;
      else valid_pipe <= {valid_pipe[`ACC_ADD_STAGES-2:0], item_valid};
   end

   // Stage one adds the low word
   always_ff @(posedge clk_ctrl) begin
      lo_q   <= {1'b0, item_a[31:0]} + {1'b0, item_b[31:0]};
      a_hi_q <= item_a[63:32];
      b_hi_q <= item_b[63:32];
   end

   // Stage two adds the high word and the carry
   always_ff @(posedge clk_ctrl) begin
      sum <= {a_hi_q + b_hi_q + {31'h0, lo_q[32]}, lo_q[31:0]};
   end

   assign sum_valid = valid_pipe[`ACC_ADD_STAGES-1];

endmodule

`default_nettype wire

// ==== packet_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "acc_config.svh"

module packet_encoder
   import acc_pkg::*;
(
   input  wire logic    clk_ctrl,
   input  wire logic    clk_ctrl_rst_low,
   input  wire word_t   hdr_data,
   input  wire logic    hdr_empty,
   input  wire result_t res_data,
   input  wire logic    res_empty,
   output logic         hdr_rd_en,
   output logic         res_rd_en,
   stream_if.sender     stream_out
);

   localparam int CNT_W = `ACC_MAX_SIZE_CODE + 2;

   typedef enum logic [1:0] {
      ST_HDR0, ST_HDR1, ST_LO, ST_HI
   } state_t;

   state_t           state;
   state_t           state_d;
   logic [CNT_W-1:0] res_cnt;   // Results left in this packet
   logic [CNT_W-1:0] res_cnt_d;
   logic             sent;

   assign sent = stream_out.valid && stream_out.ready;

   //////////////////////////////
   // Output sequencing
   //////////////////////////////

   always_comb begin
      state_d          = state;
      res_cnt_d        = res_cnt;
      hdr_rd_en        = 1'b0;
      res_rd_en        = 1'b0;
      stream_out.valid = 1'b0;
      stream_out.data  = hdr_data;
      stream_out.last  = 1'b0;
      case (state)
         ST_HDR0: begin
            // A first sum means both header words are already queued
            stream_out.valid = !hdr_empty && !res_empty;
            if (sent) begin
               hdr_rd_en = 1'b1;
               res_cnt_d = CNT_W'(1) << hdr_data[11:8];
               state_d   = ST_HDR1;
            end
         end
         ST_HDR1: begin
            stream_out.valid = !hdr_empty;
            if (sent) begin
               hdr_rd_en = 1'b1;
               state_d   = ST_LO;
            end
         end
         ST_LO: begin
            stream_out.valid = !res_empty; // Waits here for the next sum
            stream_out.data  = res_data[31:0];
            if (sent) state_d = ST_HI;
         end
         ST_HI: begin
            stream_out.valid = 1'b1;
            stream_out.data  = res_data[63:32];
            stream_out.last  = (res_cnt == CNT_W'(1));
            if (sent) begin
               res_rd_en = 1'b1;   // Pop only after both halves went out
               res_cnt_d = res_cnt - 1'b1;
               state_d   = stream_out.last ? ST_HDR0 : ST_LO;
            end
         end
         default: state_d = ST_HDR0;
      endcase
   end

   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) begin
         state   <= ST_HDR0;
         res_cnt <= '0;
      end else begin
         state   <= state_d;
         res_cnt <= res_cnt_d;
      end
   end

endmodule

`default_nettype wire

// ==== acc_tile.sv ====
`timescale 1ns/1ps
`default_nettype none

module acc_tile
   import acc_pkg::*;
(
   input  wire logic     clk_ctrl,
   input  wire logic     clk_ctrl_rst_low,
   input  wire tile_id_t src_id,     // This tile
   input  wire logic     in_valid,
   input  wire word_t    in_data,
   input  wire logic     in_last,
   output logic          in_ready,
   output logic          out_valid,
   output word_t         out_data,
   output logic          out_last,
   input  wire logic     out_ready
);

   stream_if in_stream ();
   stream_if out_stream ();

   logic    hdr_wr_en;
   word_t   hdr_wr_data;
   logic    hdr_rd_en;
   word_t   hdr_rd_data;
   logic    hdr_empty;
   logic    hdr_full;
   logic    item_valid;
   result_t item_a;
   result_t item_b;
   logic    sum_valid;
   result_t sum;
   logic    res_rd_en;
   result_t res_rd_data;
   logic    res_empty;
   logic    res_full;

   assign in_stream.valid  = in_valid;
   assign in_stream.data   = in_data;
   assign in_stream.last   = in_last;
   assign in_ready         = in_stream.ready;
   assign out_valid        = out_stream.valid;
   assign out_data         = out_stream.data;
   assign out_last         = out_stream.last;
   assign out_stream.ready = out_ready;

   packet_decoder packet_decoder_inst (
      .clk_ctrl, .clk_ctrl_rst_low, .src_id,
      .stream_in (in_stream.receiver),
      .hdr_full, .res_full,
      .hdr_wr_en, .hdr_data (hdr_wr_data),
      .item_valid, .item_a, .item_b
   );

   operand_adder operand_adder_inst (
      .clk_ctrl, .clk_ctrl_rst_low,
      .item_valid, .item_a, .item_b,
      .sum_valid, .sum
   );

   sync_fifo #(.payload_t (word_t)) hdr_fifo (
      .clk_ctrl, .clk_ctrl_rst_low,
      .wr_en (hdr_wr_en), .wr_data (hdr_wr_data),
      .rd_en (hdr_rd_en), .rd_data (hdr_rd_data),
      .empty (hdr_empty), .almost_full (hdr_full)
   );

   sync_fifo #(.payload_t (result_t)) res_fifo (
      .clk_ctrl, .clk_ctrl_rst_low,
      .wr_en (sum_valid), .wr_data (sum),
      .rd_en (res_rd_en), .rd_data (res_rd_data),
      .empty (res_empty), .almost_full (res_full)
   );

   packet_encoder packet_encoder_inst (
      .clk_ctrl, .clk_ctrl_rst_low,
      .hdr_data (hdr_rd_data), .hdr_empty,
      .res_data (res_rd_data), .res_empty,
      .hdr_rd_en, .res_rd_en,
      .stream_out (out_stream.sender)
   );

endmodule

`default_nettype wire

// ==== tb_acc_tile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "acc_config.svh"

module tb_acc_tile
   import acc_pkg::*;
();

   localparam int          WORD_TIMEOUT  = 200;  // Cycles per input word
   localparam int          DRAIN_TIMEOUT = 4000;
   localparam logic [31:0] SEED          = 32'h20aa_1d46;

   logic     clk_ctrl;
   logic     clk_ctrl_rst_low;
   tile_id_t src_id;
   logic     in_valid;
   word_t    in_data;
   logic     in_last;
   logic     in_ready;
   logic     out_valid;
   word_t    out_data;
   logic     out_last;
   logic     out_ready;

   logic [31:0] op_state;    // Operand LFSR
   logic [31:0] rdy_state;   // out_ready LFSR
   int          ready_mode;  // 0 always ready, 1 LFSR pattern, 2 held low
   word_t       exp_data[$];
   logic        exp_last[$];
   int          checked;
   int          value_errors;
   int          other_errors;

   acc_tile acc_tile_inst (
      .clk_ctrl, .clk_ctrl_rst_low, .src_id,
      .in_valid, .in_data, .in_last, .in_ready,
      .out_valid, .out_data, .out_last, .out_ready
   );

   always #10 clk_ctrl = ~clk_ctrl;

   //////////////////////////////
   // Random source
   //////////////////////////////

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic rand_word(output word_t w);
      int i;
      w = '0;
      for (i = 0; i < 32; i++) begin
         op_state = lfsr_next(op_state);
         w = {w[30:0], op_state[0]};  // One step per bit
      end
   endtask

   always @(posedge clk_ctrl) begin
      #1;
      if (ready_mode == 1) begin
         rdy_state = lfsr_next(rdy_state);
         out_ready = rdy_state[0];
      end else begin
         out_ready = (ready_mode == 0);
      end
   end

   //////////////////////////////
   // Output checker
   //////////////////////////////

   always @(posedge clk_ctrl) begin
      if (clk_ctrl_rst_low && out_valid && out_ready) begin
         assert (exp_data.size() > 0) else begin
            other_errors++;
            $display("output word %h arrived while no word was expected", out_data);
         end
         if (exp_data.size() > 0) begin
            checked++;
            assert (out_data === exp_data[0]) else begin
               value_errors++;
               $display("error out_data: got %h, expected %h", out_data, exp_data[0]);
            end
            assert (out_last === exp_last[0]) else begin
               value_errors++;
               $display("error out_last: got %h, expected %h", out_last, exp_last[0]);
            end
            void'(exp_data.pop_front());
            void'(exp_last.pop_front());
         end
      end
   end

   // Reference model of the header rewrite
   task automatic expect_header(input word_t w0, input word_t w1);
      logic [2:0] opcode;
      logic [5:0] target;
      logic [1:0] code;
      logic [5:0] dest;
      logic [3:0] size_code;
      size_code = w0[11:8] - 4'd1;
      opcode    = 3'd3;      // QPUT
      target    = w1[5:0];
      code      = 2'd0;
      dest      = 6'd0;
      if (w1[9:8] == 2'd1) begin
         opcode = 3'd4;      // MPUT
         code   = 2'd2;
         dest   = w0[23:18];
      end else if (w1[9:8] != 2'd2) begin
         target = w0[23:18]; // Return to the sender
      end
      exp_data.push_back({3'b000, 1'b1, opcode, 1'b0, src_id, 6'h00, size_code, 2'b00, target});
      exp_last.push_back(1'b0);
      exp_data.push_back({22'h0, code, 2'b00, dest});
      exp_last.push_back(1'b0);
   endtask

   task automatic send_word(input word_t data, input logic last);
      int waited;
      waited   = 0;
      in_valid = 1'b1;
      in_data  = data;
      in_last  = last;
      @(posedge clk_ctrl);
      while (!in_ready && waited < WORD_TIMEOUT) begin
         waited++;
         @(posedge clk_ctrl);
      end
      assert (in_ready) else begin
         other_errors++;
         $display("input word %h was not accepted before the timeout", data);
      end
      #1;
      in_valid = 1'b0;
      in_last  = 1'b0;
   endtask

   task automatic send_packet(input logic [3:0] size_field, input logic [1:0] route,
                              input logic [5:0] dest, input logic [5:0] target,
                              input logic carry);
      word_t   w0;
      word_t   w1;
      word_t   a_hi;
      word_t   a_lo;
      word_t   b;
      result_t sum;
      int      items;
      int      i;
      rand_word(w0);         // Unused header bits stay random
      rand_word(w1);
      w0[23:18] = dest;
      w0[11:8]  = size_field;
      w1[9:8]   = route;
      w1[5:0]   = target;
      items     = 1 << (size_field - 1);
      expect_header(w0, w1);
      send_word(w0, 1'b0);
      send_word(w1, 1'b0);
      for (i = 0; i < items; i++) begin
         rand_word(a_hi);
         rand_word(a_lo);
         rand_word(b);
         if (carry) begin
            a_lo[31:28] = 4'hf;  // Low half always carries out
            b[31:28]    = 4'hf;
         end
         sum = {a_hi, a_lo} + {32'h0, b};
         exp_data.push_back(sum[31:0]);
         exp_last.push_back(1'b0);
         exp_data.push_back(sum[63:32]);
         exp_last.push_back(i == items - 1);
         send_word(a_hi, 1'b0);
         send_word(a_lo, 1'b0);
         send_word(b, i == items - 1);
      end
   endtask

   task automatic wait_drain(input string what);
      int waited;
      waited = 0;
      while (exp_data.size() > 0 && waited < DRAIN_TIMEOUT) begin
         waited++;
         @(negedge clk_ctrl);
      end
      assert (exp_data.size() == 0) else begin
         other_errors++;
         $display("%s: %0d output words missing at the timeout", what, exp_data.size());
         exp_data.delete();
         exp_last.delete();
      end
      @(posedge clk_ctrl);
      #1;
   endtask

   //////////////////////////////
   // Directed tests
   //////////////////////////////

   task automatic reset_and_return_route();
      assert (out_valid === 1'b0) else begin
         value_errors++;
         $display("error out_valid: got %h, expected 0 after reset", out_valid);
      end
      send_packet(4'd1, 2'd0, 6'h15, 6'h2a, 1'b0);
      wait_drain("return route");
   endtask

   task automatic forward_route();
      send_packet(4'd1, 2'd1, 6'h0b, 6'h31, 1'b0);
      wait_drain("forward route");
   endtask

   task automatic final_route();
      send_packet(4'd1, 2'd2, 6'h27, 6'h06, 1'b0);
      wait_drain("final route");
   endtask

   task automatic eight_item_packet();
      send_packet(4'd4, 2'd1, 6'h3c, 6'h11, 1'b1);
      wait_drain("eight items");
   endtask

   task automatic random_ready_stream();
      ready_mode = 1;
      send_packet(4'd2, 2'd1, 6'h12, 6'h21, 1'b0);
      send_packet(4'd3, 2'd3, 6'h2e, 6'h05, 1'b1);
      send_packet(4'd1, 2'd2, 6'h09, 6'h38, 1'b0);
      wait_drain("random out_ready");
      ready_mode = 0;
   endtask

   task automatic stall_and_drain();
      int   sent;
      int   waited;
      logic blocked;
      ready_mode = 2;
      sent       = 0;
      blocked    = 1'b0;
      while (!blocked && sent < 8) begin
         send_packet(4'd3, sent[1:0], 6'h1d, 6'h33, 1'b0);
         sent++;
         waited = 0;
         while (!blocked && waited < `ACC_ADD_STAGES + 4) begin  // Sums still in flight
            @(negedge clk_ctrl);
            blocked = !in_ready;
            waited++;
         end
         @(posedge clk_ctrl);
         #1;
      end
      assert (blocked) else begin
         other_errors++;
         $display("in_ready never went low at a packet start while out_ready was low");
      end
      ready_mode = 0;
      wait_drain("drain after stall");
      @(negedge clk_ctrl);
      assert (out_valid === 1'b0) else begin
         value_errors++;
         $display("error out_valid: got %h, expected 0 once drained", out_valid);
      end
      @(posedge clk_ctrl);
      #1;
   endtask

   initial begin
      clk_ctrl         = 1'b0;
      clk_ctrl_rst_low = 1'b0;
      src_id           = 6'h2d;
      in_valid         = 1'b0;
      in_data          = '0;
      in_last          = 1'b0;
      out_ready        = 1'b1;
      op_state         = SEED;
      rdy_state        = SEED;
      ready_mode       = 0;
      checked          = 0;
      value_errors     = 0;
      other_errors     = 0;
      repeat (5) @(posedge clk_ctrl);
      #1;
      clk_ctrl_rst_low = 1'b1;
      reset_and_return_route();
      forward_route();
      final_route();
      eight_item_packet();
      random_ready_stream();
      stall_and_drain();
      $display("%0d words checked, %0d value errors, %0d other errors",
               checked, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
acc_pkg.sv
stream_if.sv
sync_fifo.sv
packet_decoder.sv
operand_adder.sv
packet_encoder.sv
acc_tile.sv
tb_acc_tile.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the acc_tile testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_acc_tile -f project.f \
   --Mdir obj_dir -o sim_acc_tile
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_output=$(./obj_dir/sim_acc_tile)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^TEST PASSED$" <<< "$sim_output"; then
   exit 0
fi
exit 1
